// ==== logic/wt_defines.svh ====
`ifndef WT_DEFINES_SVH
`define WT_DEFINES_SVH

// operand and product widths of the significand multiplier
`define WT_OPND_W 24
`define WT_PROD_W 48

`define WT_HALF_W 24      // low half resolved in the first adder stage

// middle register of the tree sits after this many 3:2 layers
`define WT_TREE_SPLIT 4
`define WT_LATENCY 5      // in_valid edge to out_valid edge

`endif

// ==== logic/mul_types_pkg.sv ====
`include "wt_defines.svh"

package mul_types_pkg;

  // one unsigned significand
  typedef logic [`WT_OPND_W-1:0] operand_t;

  // full product width and the width of every tree row
  typedef logic [`WT_PROD_W-1:0] product_t;

  // one shifted row per bit of b
  typedef product_t pp_rows_t [`WT_OPND_W];

endpackage

// ==== logic/csa_geom_pkg.sv ====
package csa_geom_pkg;

  // one 3:2 layer turns each full group of three rows into two
  // and leftover rows go through untouched
  function automatic int rows_after(input int n);
    return 2 * (n / 3) + n % 3;
  endfunction

  function automatic int rows_after_layers(input int n, input int layers);
    int rows;
    rows = n;
    for (int i = 0; i < layers; i++) begin
      rows = rows_after(rows);
    end
    return rows;
  endfunction

  // tree depth needed to get down to a sum row and a carry row
  function automatic int layers_to_two(input int n);
    int rows;
    int depth;
    rows  = n;
    depth = 0;
    while (rows > 2) begin
      rows  = rows_after(rows);
      depth = depth + 1;
    end
    return depth;
  endfunction

endpackage

// ==== logic/pp_array.sv ====
`timescale 1ns/1ps
`include "wt_defines.svh"

module pp_array
  import mul_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  output logic     pp_valid,
  output pp_rows_t rows
);

  pp_rows_t rows_d;

  // row i is a & b[i], moved up to weight 2^i
  always_comb begin
    product_t gated;
    for (int i = 0; i < `WT_OPND_W; i++) begin
      gated = '0;
      gated[`WT_OPND_W-1:0] = b[i] ? a : '0;
      rows_d[i] = gated << i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    rows <= rows_d;
  end

  // an unknown strobe would poison every valid stage behind it
  a_in_valid_known : assert property (
    @(posedge clk) rst_n |-> !$isunknown(in_valid)
  ) else $error("pp_array: in_valid is unknown outside reset");

endmodule

// ==== logic/csa_layer.sv ====
`timescale 1ns/1ps

module csa_layer
  import mul_types_pkg::*, csa_geom_pkg::*;
#(
  parameter int ROWS_IN = 3
) (
  input  product_t rows_in  [ROWS_IN],
  output product_t rows_out [rows_after(ROWS_IN)]
);

  localparam int GROUPS = ROWS_IN / 3;
  localparam int LEFT   = ROWS_IN % 3;

  // each group of three rows is a row-wide full adder
  for (genvar g = 0; g < GROUPS; g++) begin : g_grp
    product_t x;
    product_t y;
    product_t z;

    assign x = rows_in[3*g];
    assign y = rows_in[3*g+1];
    assign z = rows_in[3*g+2];

    assign rows_out[2*g]   = x ^ y ^ z;
    // majority goes one column up
    assign rows_out[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
  end

  // one or two leftover rows wait for the next layer
  for (genvar r = 0; r < LEFT; r++) begin : g_pass
    assign rows_out[2*GROUPS+r] = rows_in[3*GROUPS+r];
  end

endmodule

// ==== logic/csa_tree.sv ====
`timescale 1ns/1ps
`include "wt_defines.svh"

module csa_tree
  import mul_types_pkg::*, csa_geom_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pp_valid,
  input  pp_rows_t rows,
  output logic     red_valid,
  output product_t sum_row,
  output product_t carry_row
);

  localparam int PP_ROWS  = `WT_OPND_W;
  localparam int LAYERS   = layers_to_two(PP_ROWS);                   // 7 for 24 rows
  localparam int MID_ROWS = rows_after_layers(PP_ROWS, `WT_TREE_SPLIT);

  product_t mid_rows [MID_ROWS];
  logic     mid_valid;

  // 24 -> 16 -> 11 -> 8 -> 6 | reg | -> 4 -> 3 -> 2
  for (genvar l = 0; l < LAYERS; l++) begin : g_layer
    localparam int N_IN  = rows_after_layers(PP_ROWS, l);
    localparam int N_OUT = rows_after(N_IN);

    product_t lin  [N_IN];
    product_t lout [N_OUT];

    if (l == 0) begin : g_src_pp
      assign lin = rows;
    end else if (l == `WT_TREE_SPLIT) begin : g_src_mid
      assign lin = mid_rows;            // second half starts from the register
    end else begin : g_src_prev
      assign lin = g_layer[l-1].lout;
    end

    csa_layer #(
      .ROWS_IN(N_IN)
    ) u_layer (
      .rows_in (lin),
      .rows_out(lout)
    );
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_valid <= 1'b0;
      red_valid <= 1'b0;
    end else begin
      mid_valid <= pp_valid;
      red_valid <= mid_valid;
    end
  end

  always_ff @(posedge clk) begin
    mid_rows  <= g_layer[`WT_TREE_SPLIT-1].lout;
    sum_row   <= g_layer[LAYERS-1].lout[0];
    carry_row <= g_layer[LAYERS-1].lout[1];
  end

  // valid must ride exactly two registers through the tree
  a_valid_delay : assert property (
    @(posedge clk) $past(rst_n, 1) && $past(rst_n, 2) |-> red_valid == $past(pp_valid, 2)
  ) else $error("csa_tree: red_valid does not follow pp_valid by two cycles");

endmodule

// ==== logic/final_adder.sv ====
`timescale 1ns/1ps
`include "wt_defines.svh"

module final_adder
  import mul_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     red_valid,
  input  product_t sum_row,
  input  product_t carry_row,
  output logic     out_valid,
  output product_t product
);

  localparam int LO_W = `WT_HALF_W;
  localparam int HI_W = `WT_PROD_W - `WT_HALF_W;

  logic [LO_W:0]   lo_add;      // top bit is the carry into the high half
  logic [HI_W:0]   hi_add;
  logic [LO_W-1:0] lo_q;
  logic            lo_cy_q;
  logic [HI_W-1:0] sum_hi_q;
  logic [HI_W-1:0] carry_hi_q;
  logic            s2_valid;    // item sitting in stage two

  // stage one adds the low half
  assign lo_add = {1'b0, sum_row[LO_W-1:0]} + {1'b0, carry_row[LO_W-1:0]};

  always_ff @(posedge clk) begin
    lo_q       <= lo_add[LO_W-1:0];
    lo_cy_q    <= lo_add[LO_W];
    sum_hi_q   <= sum_row[`WT_PROD_W-1:LO_W];
    carry_hi_q <= carry_row[`WT_PROD_W-1:LO_W];
  end

  // stage two adds the high half plus the low carry
  assign hi_add = {1'b0, sum_hi_q} + {1'b0, carry_hi_q} + {{HI_W{1'b0}}, lo_cy_q};

  always_ff @(posedge clk) begin
    product <= {hi_add[HI_W-1:0], lo_q};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s2_valid  <= red_valid;
      out_valid <= s2_valid;
    end
  end

  // a 24x24 product fits in 48 bits so the tree rows never overflow either
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) s2_valid |-> !hi_add[HI_W]
  ) else $error("final_adder: carry out of bit 47");

endmodule

// ==== logic/wt_mul_top.sv ====
`timescale 1ns/1ps

module wt_mul_top
  import mul_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  output logic     out_valid,
  output product_t product
);

  logic     pp_valid;
  pp_rows_t rows;
  logic     red_valid;
  product_t sum_row;
  product_t carry_row;

  // partial products in 1 cycle
  pp_array u_pp (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_valid(in_valid),
    .a       (a),
    .b       (b),
    .pp_valid(pp_valid),
    .rows    (rows)
  );

  // carry-save reduction to two rows in 2 cycles
  csa_tree u_tree (
    .clk      (clk),
    .rst_n    (rst_n),
    .pp_valid (pp_valid),
    .rows     (rows),
    .red_valid(red_valid),
    .sum_row  (sum_row),
    .carry_row(carry_row)
  );

  // carry-propagate add in 2 cycles
  final_adder u_add (
    .clk      (clk),
    .rst_n    (rst_n),
    .red_valid(red_valid),
    .sum_row  (sum_row),
    .carry_row(carry_row),
    .out_valid(out_valid),
    .product  (product)
  );

endmodule

// ==== sim/tb_wt_mul.sv ====
`timescale 1ns/1ps
`include "wt_defines.svh"

module tb_wt_mul
  import mul_types_pkg::*;
();

  localparam int RST_CYC   = 4;
  localparam int N_QUIET   = 6;
  localparam int N_CORNER  = 7 + 2 * `WT_OPND_W;
  localparam int N_STREAM  = 500;
  localparam int N_GAP     = 300;
  localparam int N_PRE     = 6;
  localparam int MID_RST   = 2;
  localparam int N_POST    = 20;
  localparam int DRAIN_MAX = `WT_LATENCY + 2;
  localparam int TOTAL_CYCLES = RST_CYC + N_QUIET + N_CORNER + N_STREAM + N_GAP
                              + N_PRE + 1 + MID_RST + N_POST + 4 * DRAIN_MAX;

  localparam operand_t OPND_MAX = {`WT_OPND_W{1'b1}};

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  product_t    exp_q [$];
  int          due_q [$];    // cycle in which each product must show up
  int          cyc = 0;
  logic [31:0] rng = 32'h67d9;
  string       test_name;

  wt_mul_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .product  (product)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // shift and add over the bits of y
  function automatic product_t ref_mul(input operand_t x, input operand_t y);
    product_t acc;
    acc = '0;
    for (int i = 0; i < `WT_OPND_W; i++) begin
      if (y[i]) acc = acc + (product_t'(x) << i);
    end
    return acc;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand_operand(output operand_t v);
    rng = xorshift32(rng);
    v = rng[`WT_OPND_W-1:0];
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic drive_pair(input logic v, input operand_t x, input operand_t y);
    @(posedge clk);
    #1;
    in_valid = v;
    a        = x;
    b        = y;
    if (v) begin
      exp_q.push_back(ref_mul(x, y));
      due_q.push_back(cyc + `WT_LATENCY);
    end
  endtask

  task automatic drive_idle();
    drive_pair(1'b0, a, b);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) drive_idle();
  endtask

  // anything in flight is dropped by the DUT so the queues go too
  task automatic apply_reset(input int n);
    in_valid = 1'b0;
    rst_n    = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
      check_value("reset quiet", 64'd0, 64'(out_valid));
      exp_q.delete();
      due_q.delete();
    end
    rst_n = 1'b1;
  endtask

  task automatic run_corners();
    drive_pair(1'b1, '0, '0);
    drive_pair(1'b1, '0, OPND_MAX);
    drive_pair(1'b1, OPND_MAX, '0);
    drive_pair(1'b1, operand_t'(1), OPND_MAX);
    drive_pair(1'b1, operand_t'(1), operand_t'(24'h123456));
    drive_pair(1'b1, operand_t'(24'h654321), operand_t'(1));
    drive_pair(1'b1, OPND_MAX, OPND_MAX);
    for (int i = 0; i < `WT_OPND_W; i++) begin
      drive_pair(1'b1, operand_t'(1) << i, operand_t'(1) << (`WT_OPND_W - 1 - i));
    end
    for (int i = 0; i < `WT_OPND_W; i++) begin
      drive_pair(1'b1, OPND_MAX, operand_t'(1) << i);   // single bit of b
    end
  endtask

  task automatic run_random(input int n, input logic gapped);
    operand_t x;
    operand_t y;
    logic     v;
    repeat (n) begin
      rng = xorshift32(rng);
      v = gapped ? (rng[1:0] != 2'b00) : 1'b1;
      rand_operand(x);
      rand_operand(y);
      drive_pair(v, x, y);
    end
  endtask

  // compare mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("out_valid high in cycle %0d with no item pending", cyc));
      end else begin
        check_value({test_name, " output cycle"}, 64'(due_q[0]), 64'(cyc));
        check_value(test_name, 64'(exp_q[0]), 64'(product));
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end else if (exp_q.size() != 0 && due_q[0] <= cyc) begin
      abort_run($sformatf("no result came out in cycle %0d though one was due", cyc));
    end
  end

  initial begin
    #((TOTAL_CYCLES + `WT_LATENCY + 100) * 4);
    $display("watchdog expired, the simulation ran longer than the tests need");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    a         = '0;
    b         = '0;
    test_name = "reset quiet";
    apply_reset(RST_CYC);
    repeat (N_QUIET) begin
      drive_idle();
      check_value(test_name, 64'd0, 64'(out_valid));
    end

    test_name = "corner operands";
    run_corners();
    drain();

    test_name = "streaming";
    run_random(N_STREAM, 1'b0);
    drain();

    test_name = "gapped input";
    run_random(N_GAP, 1'b1);
    drain();

    // some items still inside the pipe when reset hits
    test_name = "reset mid-stream";
    run_random(N_PRE, 1'b0);
    @(posedge clk);
    #1;
    apply_reset(MID_RST);
    run_random(N_POST, 1'b0);
    drain();

    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out", exp_q.size());
      $display("TEST FAILED");
      $fatal(1);
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/mul_types_pkg.sv
logic/csa_geom_pkg.sv
logic/pp_array.sv
logic/csa_layer.sv
logic/csa_tree.sv
logic/final_adder.sv
logic/wt_mul_top.sv
sim/tb_wt_mul.sv

// ==== run_verilator.sh ====
#!/bin/sh
# build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_wt_mul \
  -f sim.f \
  -o tb_wt_mul

# the log decides the verdict, a fatal stop must not skip the search
./obj_dir/tb_wt_mul > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
